/* dedekindPkg.sv */
`default_nettype none

package dedekindPkg;

    typedef logic [127:0] botT;      // eight parts, part i at bits i*16
    typedef logic [15:0] partT;
    typedef logic [5:0] permMaskT;   // bit 5 = ABC ... bit 0 = CBA
    typedef logic [2:0] permIdxT;

    localparam permIdxT PERM_ABC = 3'd5;   // identity
    localparam permIdxT PERM_ACB = 3'd4;
    localparam permIdxT PERM_BAC = 3'd3;
    localparam permIdxT PERM_BCA = 3'd2;
    localparam permIdxT PERM_CAB = 3'd1;
    localparam permIdxT PERM_CBA = 3'd0;
    localparam permIdxT PERM_NONE = 3'd7;

    localparam int PERM_COUNT = 6;

    // index of the highest set mask bit, PERM_NONE for an empty mask
    function automatic permIdxT highestPerm(input permMaskT mask);
        permIdxT idx;
        idx = PERM_NONE;
        for (int i = 0; i < PERM_COUNT; i++) begin
            if (mask[i]) begin
                idx = permIdxT'(i);   // ascending, so the last hit wins
            end
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

/* botPermuteSelector.sv */
`timescale 1ns/1ps
`default_nettype none

module botPermuteSelector (
    input  dedekindPkg::botT     bot,
    input  dedekindPkg::permMaskT mask,
    output dedekindPkg::botT     permutedBot
);
    import dedekindPkg::*;

    partT parts [8];
    partT oneVar [3];
    partT twoVar [3];
    logic [1:0] selFirst;
    logic [1:0] selSecond;
    logic [1:0] selThird;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            parts[i] = bot[i*16 +: 16];
        end
    end

    assign oneVar[0] = parts[3'b001];
    assign oneVar[1] = parts[3'b010];
    assign oneVar[2] = parts[3'b100];

    assign twoVar[0] = parts[3'b110];   // complement of 001
    assign twoVar[1] = parts[3'b101];
    assign twoVar[2] = parts[3'b011];

    always_comb begin
        case (highestPerm(mask))
            PERM_ACB: begin
                selFirst = 2'd0;
                selSecond = 2'd2;
                selThird = 2'd1;
            end
            PERM_BAC: begin
                selFirst = 2'd1;
                selSecond = 2'd0;
                selThird = 2'd2;
            end
            PERM_BCA: begin
                selFirst = 2'd1;
                selSecond = 2'd2;
                selThird = 2'd0;
            end
            PERM_CAB: begin
                selFirst = 2'd2;
                selSecond = 2'd0;
                selThird = 2'd1;
            end
            PERM_CBA: begin
                selFirst = 2'd2;
                selSecond = 2'd1;
                selThird = 2'd0;
            end
            default: begin   // ABC, also covers an empty mask
                selFirst = 2'd0;
                selSecond = 2'd1;
                selThird = 2'd2;
            end
        endcase
    end

    assign permutedBot = {
        parts[3'b111],
        twoVar[selFirst],
        twoVar[selSecond],
        oneVar[selThird],
        twoVar[selThird],
        oneVar[selSecond],
        oneVar[selFirst],
        parts[3'b000]
    };

endmodule

`default_nettype wire

/* symmetryFilter.sv */
`timescale 1ns/1ps
`default_nettype none

module symmetryFilter #(
    parameter int EXTRA_DATA_WIDTH = 12
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        botInValid,
    input  dedekindPkg::botT            botIn,
    input  logic [EXTRA_DATA_WIDTH-1:0] extraDataIn,
    input  logic                        load,
    output logic                        maskValid,
    output dedekindPkg::botT            heldBot,
    output logic [EXTRA_DATA_WIDTH-1:0] heldExtra,
    output dedekindPkg::permMaskT       heldMask
);
    import dedekindPkg::*;

    botT perm [PERM_COUNT];
    permMaskT distinct;

    for (genvar i = 0; i < PERM_COUNT; i++) begin : genPerm
        localparam permMaskT ONE_HOT = permMaskT'(1) << i;

        botPermuteSelector selector (
            .bot        (botIn),
            .mask       (ONE_HOT),
            .permutedBot(perm[i])
        );
    end

    // a permutation counts only if no higher-priority one gives the same bot
    always_comb begin
        for (int i = 0; i < PERM_COUNT; i++) begin
            distinct[i] = 1'b1;
            for (int j = i + 1; j < PERM_COUNT; j++) begin
                if (perm[i] == perm[j]) begin
                    distinct[i] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            maskValid <= 1'b0;
        end else if (botInValid) begin
            maskValid <= 1'b1;
        end else if (load) begin
            maskValid <= 1'b0;   // slot handed over
        end
    end

    always_ff @(posedge clk) begin
        if (botInValid) begin
            heldBot <= botIn;
            heldExtra <= extraDataIn;
            heldMask <= distinct;
        end
    end

    // upstream holds a single credit, returned only by load
    inputSlotFree: assert property (
        @(posedge clk) disable iff (rst) botInValid |-> !maskValid
    ) else $error("bot arrived while filter slot is full");

endmodule

`default_nettype wire

/* botPermuter.sv */
`timescale 1ns/1ps
`default_nettype none

module botPermuter #(
    parameter int EXTRA_DATA_WIDTH = 12
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        maskValid,
    input  dedekindPkg::botT            heldBot,
    input  logic [EXTRA_DATA_WIDTH-1:0] heldExtra,
    input  dedekindPkg::permMaskT       heldMask,
    input  logic                        creditAvail,
    output logic                        load,
    output logic                        consume,
    output logic                        permutedBotValid,
    output dedekindPkg::botT            permutedBot,
    output dedekindPkg::permIdxT        selectedPermutation,
    output logic [EXTRA_DATA_WIDTH-1:0] extraDataOut
);
    import dedekindPkg::*;

    typedef enum logic {
        IDLE,
        RUN
    } permStateT;

    permStateT state;
    botT savedBot;
    logic [EXTRA_DATA_WIDTH-1:0] savedExtra;
    permMaskT remaining;
    permMaskT nextRemaining;
    permIdxT nextIdx;
    botT selectedBot;

    assign load = (state == IDLE) && maskValid;
    assign consume = (state == RUN) && creditAvail;

    assign nextIdx = highestPerm(remaining);
    assign nextRemaining = remaining & ~(permMaskT'(1) << nextIdx);   // drop retired bit

    botPermuteSelector selector (
        .bot        (savedBot),
        .mask       (remaining),
        .permutedBot(selectedBot)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            remaining <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (load) begin
                        state <= RUN;
                        remaining <= heldMask;
                    end
                end
                RUN: begin
                    if (consume) begin   // stalls here without credit
                        remaining <= nextRemaining;
                        if (nextRemaining == '0) begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            savedBot <= heldBot;
            savedExtra <= heldExtra;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            permutedBotValid <= 1'b0;
            selectedPermutation <= PERM_NONE;
        end else begin
            permutedBotValid <= consume;
            selectedPermutation <= consume ? nextIdx : PERM_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (consume) begin
            permutedBot <= selectedBot;
            extraDataOut <= savedExtra;
        end
    end

    // every retirement takes a real mask bit inside a burst
    consumeInBurst: assert property (
        @(posedge clk) disable iff (rst) consume |-> (state == RUN) && (remaining != '0)
    ) else $error("consume outside a burst");

    // the filter always marks the identity, so a burst is never empty
    loadedMaskNotEmpty: assert property (
        @(posedge clk) disable iff (rst) load |=> remaining != '0
    ) else $error("empty mask loaded");

endmodule

`default_nettype wire

/* creditPool.sv */
`timescale 1ns/1ps
`default_nettype none

module creditPool #(
    parameter int OUT_CREDITS = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic outCredit,
    input  logic consume,
    output logic creditAvail
);
    localparam int COUNT_WIDTH = $clog2(OUT_CREDITS + 1);

    typedef logic [COUNT_WIDTH-1:0] countT;

    localparam countT FULL = countT'(OUT_CREDITS);

    countT count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= FULL;   // initial downstream grant
        end else begin
            case ({outCredit, consume})
                2'b10: count <= count + countT'(1);
                2'b01: count <= count - countT'(1);
                default: count <= count;   // none, or return and use together
            endcase
        end
    end

    assign creditAvail = count != '0;

    // downstream never returns more than it granted
    noOverflow: assert property (
        @(posedge clk) disable iff (rst) (outCredit && !consume) |-> count < FULL
    ) else $error("output credit overflow");

    noUnderflow: assert property (
        @(posedge clk) disable iff (rst) consume |-> count != '0
    ) else $error("consume with no credit");

endmodule

`default_nettype wire

/* botPermutePipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module botPermutePipeline #(
    parameter int EXTRA_DATA_WIDTH = 12,
    parameter int OUT_CREDITS = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        botInValid,
    input  dedekindPkg::botT            botIn,
    input  logic [EXTRA_DATA_WIDTH-1:0] extraDataIn,
    output logic                        inCredit,
    input  logic                        outCredit,
    output logic                        permutedBotValid,
    output dedekindPkg::botT            permutedBot,
    output dedekindPkg::permIdxT        selectedPermutation,
    output logic [EXTRA_DATA_WIDTH-1:0] extraDataOut
);
    import dedekindPkg::*;

    logic maskValid;
    botT heldBot;
    logic [EXTRA_DATA_WIDTH-1:0] heldExtra;
    permMaskT heldMask;
    logic load;
    logic consume;
    logic creditAvail;

    symmetryFilter #(
        .EXTRA_DATA_WIDTH(EXTRA_DATA_WIDTH)
    ) filter (
        .clk        (clk),
        .rst        (rst),
        .botInValid (botInValid),
        .botIn      (botIn),
        .extraDataIn(extraDataIn),
        .load       (load),
        .maskValid  (maskValid),
        .heldBot    (heldBot),
        .heldExtra  (heldExtra),
        .heldMask   (heldMask)
    );

    botPermuter #(
        .EXTRA_DATA_WIDTH(EXTRA_DATA_WIDTH)
    ) permuter (
        .clk                (clk),
        .rst                (rst),
        .maskValid          (maskValid),
        .heldBot            (heldBot),
        .heldExtra          (heldExtra),
        .heldMask           (heldMask),
        .creditAvail        (creditAvail),
        .load               (load),
        .consume            (consume),
        .permutedBotValid   (permutedBotValid),
        .permutedBot        (permutedBot),
        .selectedPermutation(selectedPermutation),
        .extraDataOut       (extraDataOut)
    );

    creditPool #(
        .OUT_CREDITS(OUT_CREDITS)
    ) pool (
        .clk        (clk),
        .rst        (rst),
        .outCredit  (outCredit),
        .consume    (consume),
        .creditAvail(creditAvail)
    );

    assign inCredit = load;   // hand-off frees the filter slot

endmodule

`default_nettype wire

/* botPermutePipelineTb.sv */
`timescale 1ns/1ps
`default_nettype none

module botPermutePipelineTb;
    import dedekindPkg::*;

    localparam int EXTRA_DATA_WIDTH = 12;
    localparam int OUT_CREDITS = 4;
    localparam int CLK_PERIOD = 100;
    localparam int DRAIN_LIMIT = 2000;   // cycles per wait
    localparam int TOTAL_BOTS = 61;
    localparam int WATCHDOG_CYCLES = TOTAL_BOTS * 6 * 25 * 2;   // slowest credit delay, x2 margin

    typedef logic [EXTRA_DATA_WIDTH-1:0] tagT;

    logic clk = 1'b0;
    logic rst;
    logic botInValid;
    botT botIn;
    tagT extraDataIn;
    logic inCredit;
    logic outCredit;
    logic permutedBotValid;
    botT permutedBot;
    permIdxT selectedPermutation;
    tagT extraDataOut;

    botT expBot [$];
    permIdxT expIdx [$];
    tagT expTag [$];
    int creditDue [$];   // cycle at which each credit goes back
    integer seed;
    string testName;
    int errors = 0;
    int cycle = 0;
    int outCount = 0;
    int creditsReturned = 0;
    int inCreditCount = 0;
    int heldInCredits = 1;   // upstream starts with one credit
    int acceptedBots = 0;
    int creditDelay = 1;
    logic randomDelay = 1'b0;

    botPermutePipeline #(
        .EXTRA_DATA_WIDTH(EXTRA_DATA_WIDTH),
        .OUT_CREDITS     (OUT_CREDITS)
    ) botPermutePipeline_i (
        .clk                (clk),
        .rst                (rst),
        .botInValid         (botInValid),
        .botIn              (botIn),
        .extraDataIn        (extraDataIn),
        .inCredit           (inCredit),
        .outCredit          (outCredit),
        .permutedBotValid   (permutedBotValid),
        .permutedBot        (permutedBot),
        .selectedPermutation(selectedPermutation),
        .extraDataOut       (extraDataOut)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // source variable for positions {C, B, A}, read off the permutation name
    function automatic logic [5:0] sourceVars(input int idx);
        case (idx)
            5: return {2'd2, 2'd1, 2'd0};   // ABC
            4: return {2'd1, 2'd2, 2'd0};   // ACB
            3: return {2'd2, 2'd0, 2'd1};   // BAC
            2: return {2'd0, 2'd2, 2'd1};   // BCA
            1: return {2'd1, 2'd0, 2'd2};   // CAB
            default: return {2'd0, 2'd1, 2'd2};   // CBA
        endcase
    endfunction

    // renames the variables in every subset code, parts 000 and 111 stay put
    function automatic botT modelPermute(input botT bot, input int idx);
        logic [5:0] src;
        logic [2:0] from;
        botT result;
        src = sourceVars(idx);
        for (int code = 0; code < 8; code++) begin
            from = 3'b000;
            for (int pos = 0; pos < 3; pos++) begin
                if (code[pos]) begin
                    from[src[pos*2 +: 2]] = 1'b1;
                end
            end
            result[code*16 +: 16] = bot[from*16 +: 16];
        end
        return result;
    endfunction

    function automatic permMaskT modelMask(input botT bot);
        botT results [6];
        permMaskT mask;
        for (int i = 0; i < 6; i++) begin
            results[i] = modelPermute(bot, i);
        end
        mask = '0;
        for (int i = 5; i >= 0; i--) begin
            mask[i] = 1'b1;
            for (int j = 5; j > i; j--) begin
                if (results[j] == results[i]) begin
                    mask[i] = 1'b0;   // same bot as a higher priority one
                end
            end
        end
        return mask;
    endfunction

    function automatic botT randomBot();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // downstream buffer, one credit back per output after a delay
    initial begin
        outCredit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            cycle++;
            if (creditDue.size() != 0 && creditDue[0] <= cycle) begin
                void'(creditDue.pop_front());
                outCredit = 1'b1;
                creditsReturned++;
            end else begin
                outCredit = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (inCredit === 1'b1) begin
            inCreditCount++;
            heldInCredits++;
        end
        if (permutedBotValid === 1'b1) begin
            outCount++;
            if (selectedPermutation == PERM_NONE) begin
                errors++;
                $display("%s: valid output carries no permutation index", testName);
            end
            if (expIdx.size() == 0) begin
                errors++;
                $display("%s: output arrived with none expected", testName);
            end else begin
                if (permutedBot !== expBot[0]) begin
                    errors++;
                    $display("mismatch %s bot: expected %h actual %h",
                             testName, expBot[0], permutedBot);
                end
                if (selectedPermutation !== expIdx[0]) begin
                    errors++;
                    $display("mismatch %s index: expected %0d actual %0d",
                             testName, expIdx[0], selectedPermutation);
                end
                if (extraDataOut !== expTag[0]) begin
                    errors++;
                    $display("mismatch %s tag: expected %h actual %h",
                             testName, expTag[0], extraDataOut);
                end
                void'(expBot.pop_front());
                void'(expIdx.pop_front());
                void'(expTag.pop_front());
            end
            if (randomDelay) begin
                creditDue.push_back(cycle + 1 + int'($unsigned($random(seed)) % 8));
            end else begin
                creditDue.push_back(cycle + creditDelay);
            end
            if (outCount - creditsReturned > OUT_CREDITS) begin
                errors++;
                $display("%s: more outputs than granted output credits", testName);
            end
        end
    end

    task automatic sendBot(input botT bot, input tagT tag);
        permMaskT mask;
        int waited;
        waited = 0;
        while (heldInCredits == 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (heldInCredits == 0) begin
            errors++;
            $display("%s: input credit never came back", testName);
        end else begin
            mask = modelMask(bot);
            for (int i = 5; i >= 0; i--) begin
                if (mask[i]) begin
                    expBot.push_back(modelPermute(bot, i));
                    expIdx.push_back(permIdxT'(i));
                    expTag.push_back(tag);
                end
            end
            botInValid = 1'b1;
            botIn = bot;
            extraDataIn = tag;
            heldInCredits--;
            acceptedBots++;
            @(posedge clk);
            #1;
            botInValid = 1'b0;
        end
    endtask

    task automatic drainOutputs();
        int waited;
        waited = 0;
        while (expIdx.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (expIdx.size() != 0) begin
            errors++;
            $display("%s: %0d expected outputs never arrived", testName, expIdx.size());
        end
        repeat (4) begin   // room for a stray extra output
            @(posedge clk);
            #1;
        end
        if (inCreditCount != acceptedBots) begin
            errors++;
            $display("mismatch %s inCredit pulses: expected %0d actual %0d",
                     testName, acceptedBots, inCreditCount);
        end
    endtask

    task automatic asymmetricTest();
        botT bot;
        testName = "asymmetric";
        creditDelay = 2;
        bot = randomBot();
        while (modelMask(bot) != 6'b111111) begin
            bot = randomBot();
        end
        sendBot(bot, tagT'(12'h5a3));
        drainOutputs();
    endtask

    task automatic symmetricTest();
        partT oneVar;
        partT twoVar;
        botT bot;
        testName = "fullySymmetric";
        oneVar = 16'h1234;
        twoVar = 16'hbeef;
        bot = {16'h7777, twoVar, twoVar, oneVar, twoVar, oneVar, oneVar, 16'h0f0f};
        if (modelMask(bot) != 6'b100000) begin
            errors++;
            $display("mismatch %s mask: expected 20 actual %h", testName, modelMask(bot));
        end
        sendBot(bot, tagT'(12'h001));
        drainOutputs();
        testName = "symmetricAB";
        bot = randomBot();
        bot[2*16 +: 16] = bot[1*16 +: 16];   // A and B parts equal
        bot[6*16 +: 16] = bot[5*16 +: 16];
        sendBot(bot, tagT'(12'h002));
        drainOutputs();
    endtask

    task automatic backPressureTest();
        testName = "backPressure";
        creditDelay = 20;
        for (int i = 0; i < 3; i++) begin
            sendBot(randomBot(), tagT'(12'h100 + i));
        end
        drainOutputs();
    endtask

    task automatic inputCreditTest();
        testName = "inputCredit";
        creditDelay = 1;
        for (int i = 0; i < 5; i++) begin
            sendBot(randomBot(), tagT'(12'h200 + i));
        end
        drainOutputs();
    endtask

    task automatic randomSoakTest();
        testName = "randomSoak";
        randomDelay = 1'b1;
        for (int i = 0; i < 50; i++) begin
            sendBot(randomBot(), tagT'($random(seed)));
        end
        drainOutputs();
        randomDelay = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles in %s", WATCHDOG_CYCLES, testName);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        seed = 32'hc3b6;
        testName = "reset";
        rst = 1'b1;
        botInValid = 1'b0;
        botIn = '0;
        extraDataIn = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        asymmetricTest();
        symmetricTest();
        backPressureTest();
        inputCreditTest();
        randomSoakTest();
        $display("errors: %0d  outputs: %0d  bots: %0d", errors, outCount, acceptedBots);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* botPermutePipeline.f */
dedekindPkg.sv
botPermuteSelector.sv
symmetryFilter.sv
botPermuter.sv
creditPool.sv
botPermutePipeline.sv
botPermutePipelineTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Build and run the bot permute pipeline testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f botPermutePipeline.f \
    --top-module botPermutePipelineTb \
    -o simv

# the simulation status is judged from the log below
./obj_dir/simv 2>&1 | tee sim.log || true

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
